/* files.f */
+incdir+source
source/cache_bank_pkg.sv
source/bank_request_gate.sv
source/bank_tag_store.sv
source/bank_data_store.sv
source/bank_lookup_fsm.sv
source/cache_bank_top.sv
tests/cache_bank_checker.sv
tests/cache_bank_tb.sv

/* source/bank_data_store.sv */
`timescale 1ns/1ps
`include "cache_bank_macros.svh"

module bank_data_store
(
    input  logic                      clk_in,
    input  cache_bank_pkg::set_idx_t  set_idx,
    input  logic                      read_en,
    input  cache_bank_pkg::way_mask_t read_way,
    input  logic                      fill,
    input  cache_bank_pkg::way_mask_t fill_way,
    input  cache_bank_pkg::block_t    fill_data,
    output cache_bank_pkg::block_t    read_data
);

    cache_bank_pkg::block_t mem [`CB_NUM_SET][`CB_NUM_WAY];
    cache_bank_pkg::block_t read_mux;

    // one-hot way select folded into an or tree
    always_comb
    begin
        read_mux = '0;
        for (int w = 0; w < `CB_NUM_WAY; w++)
        begin
            if (read_way[w])
            begin
                read_mux = read_mux | mem[set_idx][w];
            end
        end
    end

    always_ff @(posedge clk_in)
    begin
        if (read_en)
        begin
            read_data <= read_mux;
        end
        for (int w = 0; w < `CB_NUM_WAY; w++)
        begin
            if (fill && fill_way[w])
            begin
                mem[set_idx][w] <= fill_data;
            end
        end
    end

endmodule

/* source/bank_lookup_fsm.sv */
`timescale 1ns/1ps

module bank_lookup_fsm
(
    input  logic                        clk_in,
    input  logic                        reset_in,
    input  logic                        start,
    input  cache_bank_pkg::access_pkt_t held_packet,
    input  cache_bank_pkg::way_mask_t   hit_way,
    input  cache_bank_pkg::block_t      read_data,
    input  logic                        miss_ack,
    input  logic                        fetched_valid,
    input  cache_bank_pkg::block_t      fetched_data,
    input  logic                        return_ack,
    output logic                        touch,
    output logic                        read_en,
    output logic                        fill,
    output logic                        done,
    output cache_bank_pkg::access_pkt_t miss_request,
    output logic                        miss_valid,
    output logic                        fetched_ack,
    output cache_bank_pkg::return_pkt_t return_packet,
    output logic                        return_valid
);

    cache_bank_pkg::lookup_state_t state;
    cache_bank_pkg::block_t        ret_data;
    logic                          hit;
    logic                          in_judge;
    logic                          load_ret;

    assign hit      = |hit_way;
    assign in_judge = (state == cache_bank_pkg::LK_JUDGE);

    // history update and data read start together in the judge cycle
    assign touch   = in_judge & hit;
    assign read_en = in_judge & hit;
    assign fill    = (state == cache_bank_pkg::LK_FILL) & fetched_valid;

    assign load_ret = (state == cache_bank_pkg::LK_HIT) | fill;
    assign ret_data = (state == cache_bank_pkg::LK_HIT) ? read_data : fetched_data;

    always_ff @(posedge clk_in or posedge reset_in)
    begin
        if (reset_in)
        begin
            state        <= cache_bank_pkg::LK_IDLE;
            miss_valid   <= 1'b0;
            fetched_ack  <= 1'b0;
            return_valid <= 1'b0;
            done         <= 1'b0;
        end
        else
        begin
            fetched_ack <= 1'b0;
            done        <= 1'b0;
            case (state)
                cache_bank_pkg::LK_IDLE:
                begin
                    if (start)
                    begin
                        state <= cache_bank_pkg::LK_JUDGE;
                    end
                end
                cache_bank_pkg::LK_JUDGE:
                begin
                    if (hit)
                    begin
                        state <= cache_bank_pkg::LK_HIT;
                    end
                    else
                    begin
                        state      <= cache_bank_pkg::LK_MISS;
                        miss_valid <= 1'b1;
                    end
                end
                // registered data read lands here
                cache_bank_pkg::LK_HIT:
                begin
                    state        <= cache_bank_pkg::LK_RETURN;
                    return_valid <= 1'b1;
                end
                cache_bank_pkg::LK_MISS:
                begin
                    if (miss_ack)
                    begin
                        state      <= cache_bank_pkg::LK_FILL;
                        miss_valid <= 1'b0;
                    end
                end
                cache_bank_pkg::LK_FILL:
                begin
                    if (fetched_valid)
                    begin
                        state        <= cache_bank_pkg::LK_RETURN;
                        fetched_ack  <= 1'b1;
                        return_valid <= 1'b1;
                    end
                end
                cache_bank_pkg::LK_RETURN:
                begin
                    if (return_ack)
                    begin
                        state        <= cache_bank_pkg::LK_IDLE;
                        return_valid <= 1'b0;
                        done         <= 1'b1;
                    end
                end
                default:
                begin
                    state <= cache_bank_pkg::LK_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk_in)
    begin
        if (in_judge && !hit)
        begin
            miss_request <= held_packet;
        end
        if (load_ret)
        begin
            return_packet.port <= held_packet.port;
            return_packet.addr <= held_packet.addr;
            return_packet.data <= ret_data;
        end
    end

endmodule

/* source/bank_request_gate.sv */
`timescale 1ns/1ps

module bank_request_gate
(
    input  logic                        clk_in,
    input  logic                        reset_in,
    input  cache_bank_pkg::access_pkt_t access_packet,
    input  logic                        done,
    output cache_bank_pkg::access_pkt_t held_packet,
    output logic                        start,
    output logic                        access_ack
);

    logic bank_lock;
    logic take;

    // one request in flight per bank
    assign take = access_packet.valid & ~bank_lock;

    always_ff @(posedge clk_in or posedge reset_in)
    begin
        if (reset_in)
        begin
            bank_lock  <= 1'b0;
            start      <= 1'b0;
            access_ack <= 1'b0;
        end
        else
        begin
            start      <= take;
            access_ack <= bank_lock & done;
            if (take)
            begin
                bank_lock <= 1'b1;
            end
            else if (done)
            begin
                bank_lock <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_in)
    begin
        if (take)
        begin
            held_packet <= access_packet;
        end
    end

endmodule

/* source/bank_tag_store.sv */
`timescale 1ns/1ps
`include "cache_bank_macros.svh"

module bank_tag_store
(
    input  logic                      clk_in,
    input  logic                      reset_in,
    input  cache_bank_pkg::set_idx_t  set_idx,
    input  cache_bank_pkg::tag_t      tag,
    input  logic                      touch,
    input  logic                      fill,
    output cache_bank_pkg::way_mask_t hit_way,
    output cache_bank_pkg::way_mask_t victim_way
);

    cache_bank_pkg::way_mask_t valid_q [`CB_NUM_SET];
    cache_bank_pkg::way_mask_t hist_q  [`CB_NUM_SET];
    cache_bank_pkg::tag_t      tag_q   [`CB_NUM_SET][`CB_NUM_WAY];

    cache_bank_pkg::way_mask_t set_valid;
    cache_bank_pkg::way_mask_t set_hist;
    cache_bank_pkg::way_mask_t free_valid;
    cache_bank_pkg::way_mask_t free_hist;
    cache_bank_pkg::way_mask_t upd_way;
    cache_bank_pkg::way_mask_t hist_or;
    cache_bank_pkg::way_mask_t hist_next;

    assign set_valid = valid_q[set_idx];
    assign set_hist  = hist_q[set_idx];

    always_comb
    begin
        for (int w = 0; w < `CB_NUM_WAY; w++)
        begin
            hit_way[w] = set_valid[w] && (tag_q[set_idx][w] == tag);
        end
    end

    // lowest clear bit as one-hot, adding one carries into it
    assign free_valid = ~set_valid & (set_valid + 1'b1);
    assign free_hist  = ~set_hist & (set_hist + 1'b1);

    // an empty way first, else the lowest way not recently used
    assign victim_way = (&set_valid) ? free_hist : free_valid;

    assign upd_way = touch ? hit_way : victim_way;
    assign hist_or = set_hist | upd_way;

    // history never saturates, a full set restarts from the used way
    assign hist_next = (&hist_or) ? upd_way : hist_or;

    always_ff @(posedge clk_in or posedge reset_in)
    begin
        if (reset_in)
        begin
            for (int s = 0; s < `CB_NUM_SET; s++)
            begin
                valid_q[s] <= '0;
                hist_q[s]  <= '0;
            end
        end
        else
        begin
            if (fill)
            begin
                valid_q[set_idx] <= set_valid | victim_way;
            end
            if (touch | fill)
            begin
                hist_q[set_idx] <= hist_next;
            end
        end
    end

    always_ff @(posedge clk_in)
    begin
        if (fill)
        begin
            for (int w = 0; w < `CB_NUM_WAY; w++)
            begin
                if (victim_way[w])
                begin
                    tag_q[set_idx][w] <= tag;
                end
            end
        end
    end

endmodule

/* source/cache_bank_macros.svh */
`ifndef CACHE_BANK_MACROS_SVH
`define CACHE_BANK_MACROS_SVH

// byte address as seen by the requester
`define CB_ADDR_W     16

// address split, tag | index | offset
`define CB_OFFSET_W   2
`define CB_INDEX_W    2
`define CB_TAG_W      12

// bank geometry
`define CB_NUM_SET    4
`define CB_NUM_WAY    4

// one block per line
`define CB_BLOCK_W    32

// requester port number
`define CB_PORT_W     2

`endif

/* source/cache_bank_pkg.sv */
`include "cache_bank_macros.svh"

package cache_bank_pkg;

    // address slice positions, tag at the top end
    localparam int OFFSET_LO = 0;
    localparam int OFFSET_HI = `CB_OFFSET_W - 1;
    localparam int INDEX_LO  = `CB_OFFSET_W;
    localparam int INDEX_HI  = `CB_OFFSET_W + `CB_INDEX_W - 1;
    localparam int TAG_LO    = `CB_OFFSET_W + `CB_INDEX_W;
    localparam int TAG_HI    = `CB_ADDR_W - 1;

    typedef logic [`CB_ADDR_W-1:0]  addr_t;
    typedef logic [`CB_INDEX_W-1:0] set_idx_t;
    typedef logic [`CB_TAG_W-1:0]   tag_t;
    typedef logic [`CB_NUM_WAY-1:0] way_mask_t;
    typedef logic [`CB_BLOCK_W-1:0] block_t;
    typedef logic [`CB_PORT_W-1:0]  port_t;

    // request from a port, also reused for the miss request
    typedef struct packed {
        logic  valid;
        port_t port;
        addr_t addr;
    } access_pkt_t;

    typedef struct packed {
        port_t  port;
        addr_t  addr;
        block_t data;
    } return_pkt_t;

    typedef enum logic [2:0] {
        LK_IDLE,
        LK_JUDGE,
        LK_HIT,
        LK_MISS,
        LK_FILL,
        LK_RETURN
    } lookup_state_t;

endpackage

/* source/cache_bank_top.sv */
`timescale 1ns/1ps

module cache_bank_top
(
    input  logic                        clk_in,
    input  logic                        reset_in,
    input  cache_bank_pkg::access_pkt_t access_packet,
    output logic                        access_ack,
    output cache_bank_pkg::access_pkt_t miss_request,
    output logic                        miss_valid,
    input  logic                        miss_ack,
    input  logic                        fetched_valid,
    input  cache_bank_pkg::block_t      fetched_data,
    output logic                        fetched_ack,
    output cache_bank_pkg::return_pkt_t return_packet,
    output logic                        return_valid,
    input  logic                        return_ack
);

    cache_bank_pkg::access_pkt_t held_packet;
    cache_bank_pkg::set_idx_t    set_idx;
    cache_bank_pkg::tag_t        tag;
    cache_bank_pkg::way_mask_t   hit_way;
    cache_bank_pkg::way_mask_t   victim_way;
    cache_bank_pkg::block_t      read_data;
    logic                        start;
    logic                        done;
    logic                        touch;
    logic                        read_en;
    logic                        fill;

    assign set_idx = held_packet.addr[cache_bank_pkg::INDEX_HI:cache_bank_pkg::INDEX_LO];
    assign tag     = held_packet.addr[cache_bank_pkg::TAG_HI:cache_bank_pkg::TAG_LO];

    bank_request_gate u_gate
    (
        .clk_in        (clk_in),
        .reset_in      (reset_in),
        .access_packet (access_packet),
        .done          (done),
        .held_packet   (held_packet),
        .start         (start),
        .access_ack    (access_ack)
    );

    bank_tag_store u_tags
    (
        .clk_in     (clk_in),
        .reset_in   (reset_in),
        .set_idx    (set_idx),
        .tag        (tag),
        .touch      (touch),
        .fill       (fill),
        .hit_way    (hit_way),
        .victim_way (victim_way)
    );

    bank_data_store u_data
    (
        .clk_in    (clk_in),
        .set_idx   (set_idx),
        .read_en   (read_en),
        .read_way  (hit_way),
        .fill      (fill),
        .fill_way  (victim_way),
        .fill_data (fetched_data),
        .read_data (read_data)
    );

    bank_lookup_fsm u_fsm
    (
        .clk_in        (clk_in),
        .reset_in      (reset_in),
        .start         (start),
        .held_packet   (held_packet),
        .hit_way       (hit_way),
        .read_data     (read_data),
        .miss_ack      (miss_ack),
        .fetched_valid (fetched_valid),
        .fetched_data  (fetched_data),
        .return_ack    (return_ack),
        .touch         (touch),
        .read_en       (read_en),
        .fill          (fill),
        .done          (done),
        .miss_request  (miss_request),
        .miss_valid    (miss_valid),
        .fetched_ack   (fetched_ack),
        .return_packet (return_packet),
        .return_valid  (return_valid)
    );

endmodule

/* tests/cache_bank_checker.sv */
`timescale 1ns/1ps

module cache_bank_checker
(
    input logic                        clk_in,
    input logic                        reset_in,
    input logic                        access_ack,
    input cache_bank_pkg::access_pkt_t miss_request,
    input logic                        miss_valid,
    input logic                        miss_ack,
    input cache_bank_pkg::return_pkt_t return_packet,
    input logic                        return_valid,
    input logic                        return_ack
);

    int fail_count;

    initial
    begin
        fail_count = 0;
    end

    // pending miss request holds until taken
    a_miss_hold : assert property (
        @(posedge clk_in) disable iff (reset_in)
        (miss_valid && !miss_ack) |=> (miss_valid && $stable(miss_request)))
    else
    begin
        $error("miss request changed or dropped before miss_ack");
        fail_count = fail_count + 1;
    end

    a_return_hold : assert property (
        @(posedge clk_in) disable iff (reset_in)
        (return_valid && !return_ack) |=> (return_valid && $stable(return_packet)))
    else
    begin
        $error("return packet changed or dropped before return_ack");
        fail_count = fail_count + 1;
    end

    a_ack_pulse : assert property (
        @(posedge clk_in) disable iff (reset_in)
        access_ack |=> !access_ack)
    else
    begin
        $error("access_ack stayed high for more than one cycle");
        fail_count = fail_count + 1;
    end

    a_one_sided : assert property (
        @(posedge clk_in) disable iff (reset_in)
        !(miss_valid && return_valid))
    else
    begin
        $error("miss_valid and return_valid high in the same cycle");
        fail_count = fail_count + 1;
    end

endmodule

bind cache_bank_top cache_bank_checker u_checker
(
    .clk_in        (clk_in),
    .reset_in      (reset_in),
    .access_ack    (access_ack),
    .miss_request  (miss_request),
    .miss_valid    (miss_valid),
    .miss_ack      (miss_ack),
    .return_packet (return_packet),
    .return_valid  (return_valid),
    .return_ack    (return_ack)
);

/* tests/cache_bank_tb.sv */
`timescale 1ns/1ps
`include "cache_bank_macros.svh"

module cache_bank_tb;

    localparam int NUM_READS    = 300;
    localparam int CYCLE_LIMIT  = NUM_READS * 40;
    localparam int TAGS_PER_SET = 6;

    logic                        clk_in;
    logic                        reset_in;
    cache_bank_pkg::access_pkt_t access_packet;
    logic                        access_ack;
    cache_bank_pkg::access_pkt_t miss_request;
    logic                        miss_valid;
    logic                        miss_ack;
    logic                        fetched_valid;
    cache_bank_pkg::block_t      fetched_data;
    logic                        fetched_ack;
    cache_bank_pkg::return_pkt_t return_packet;
    logic                        return_valid;
    logic                        return_ack;

    // cache and memory model
    cache_bank_pkg::way_mask_t m_valid [`CB_NUM_SET];
    cache_bank_pkg::way_mask_t m_hist  [`CB_NUM_SET];
    cache_bank_pkg::tag_t      m_tag   [`CB_NUM_SET][`CB_NUM_WAY];
    cache_bank_pkg::block_t    m_data  [`CB_NUM_SET][`CB_NUM_WAY];
    cache_bank_pkg::block_t    mem_model [cache_bank_pkg::addr_t];

    int errors;
    int checks;
    int hits;
    int misses;
    int cycle_count;

    cache_bank_top u_dut
    (
        .clk_in        (clk_in),
        .reset_in      (reset_in),
        .access_packet (access_packet),
        .access_ack    (access_ack),
        .miss_request  (miss_request),
        .miss_valid    (miss_valid),
        .miss_ack      (miss_ack),
        .fetched_valid (fetched_valid),
        .fetched_data  (fetched_data),
        .fetched_ack   (fetched_ack),
        .return_packet (return_packet),
        .return_valid  (return_valid),
        .return_ack    (return_ack)
    );

    always #20 clk_in = ~clk_in;

    always @(posedge clk_in)
    begin
        cycle_count = cycle_count + 1;
        if (cycle_count > CYCLE_LIMIT)
        begin
            $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("TEST FAIL");
            $finish;
        end
    end

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] expected);
        checks++;
        if (got !== expected)
        begin
            errors++;
            $display("Error: %s is %h, expected %h at %0t", name, got, expected, $time);
        end
    endtask

    task automatic next_cycle();
        @(posedge clk_in);
        #1;
    endtask

    function automatic int find_way(input int s, input cache_bank_pkg::tag_t t);
        int found;
        found = -1;
        for (int w = 0; w < `CB_NUM_WAY; w++)
        begin
            if (found < 0 && m_valid[s][w] && m_tag[s][w] == t)
            begin
                found = w;
            end
        end
        return found;
    endfunction

    // empty way first, then lowest way with history clear
    function automatic int pick_victim(input int s);
        int v;
        v = -1;
        for (int w = 0; w < `CB_NUM_WAY; w++)
        begin
            if (v < 0 && !m_valid[s][w])
            begin
                v = w;
            end
        end
        for (int w = 0; w < `CB_NUM_WAY; w++)
        begin
            if (v < 0 && !m_hist[s][w])
            begin
                v = w;
            end
        end
        return (v < 0) ? 0 : v;
    endfunction

    function automatic void mark_used(input int s, input int w);
        m_hist[s][w] = 1'b1;
        if (m_hist[s] == '1)
        begin
            m_hist[s]    = '0;
            m_hist[s][w] = 1'b1;
        end
    endfunction

    task automatic do_read(input cache_bank_pkg::port_t port, input cache_bank_pkg::addr_t addr);
        cache_bank_pkg::set_idx_t s;
        cache_bank_pkg::tag_t     t;
        cache_bank_pkg::addr_t    blk;
        cache_bank_pkg::block_t   exp_data;
        int   way;
        int   edges;
        int   fetch_wait;
        int   ack_due;
        logic model_hit;
        logic miss_taken;
        logic ret_up;
        logic ret_done;
        logic strobe_prev;
        logic finished;

        s   = addr[cache_bank_pkg::INDEX_HI:cache_bank_pkg::INDEX_LO];
        t   = addr[cache_bank_pkg::TAG_HI:cache_bank_pkg::TAG_LO];
        blk = addr;
        blk[cache_bank_pkg::OFFSET_HI:cache_bank_pkg::OFFSET_LO] = '0;
        way = find_way(s, t);
        model_hit = (way >= 0);
        if (model_hit)
        begin
            exp_data = m_data[s][way];
            hits++;
        end
        else
        begin
            if (!mem_model.exists(blk))
            begin
                mem_model[blk] = $urandom();
            end
            exp_data = mem_model[blk];
            way = pick_victim(s);
            m_valid[s][way] = 1'b1;
            m_tag[s][way]   = t;
            m_data[s][way]  = exp_data;
            misses++;
        end
        mark_used(s, way);

        access_packet.valid = 1'b1;
        access_packet.port  = port;
        access_packet.addr  = addr;
        edges       = -1;
        fetch_wait  = 0;
        ack_due     = 0;
        miss_taken  = 1'b0;
        ret_up      = 1'b0;
        ret_done    = 1'b0;
        strobe_prev = 1'b0;
        finished    = 1'b0;

        while (!finished)
        begin
            next_cycle();
            // edge 0 is the accepting edge
            edges++;
            if (ack_due > 0)
            begin
                ack_due--;
            end
            if ((model_hit && edges == 3) || strobe_prev)
            begin
                ret_up = 1'b1;
            end
            check_value("fetched_ack", fetched_ack, strobe_prev);
            check_value("miss_valid", miss_valid, !model_hit && edges >= 2 && !miss_taken);
            check_value("return_valid", return_valid, ret_up && !ret_done);
            check_value("access_ack", access_ack, ret_done && ack_due == 0);
            if (miss_valid)
            begin
                check_value("miss_request", miss_request, access_packet);
            end
            if (return_valid)
            begin
                check_value("return_packet.port", return_packet.port, port);
                check_value("return_packet.addr", return_packet.addr, addr);
                check_value("return_packet.data", return_packet.data, exp_data);
            end

            if (ret_done && ack_due == 0)
            begin
                finished = 1'b1;
            end
            else
            begin
                fetched_valid = 1'b0;
                if (fetch_wait > 0)
                begin
                    fetch_wait--;
                    if (fetch_wait == 0)
                    begin
                        fetched_valid = 1'b1;
                        fetched_data  = exp_data;
                    end
                end
                strobe_prev = fetched_valid;
                miss_ack    = $urandom_range(0, 1);
                return_ack  = $urandom_range(0, 1);
                // handshakes complete at the coming edge
                if (miss_valid && miss_ack)
                begin
                    miss_taken = 1'b1;
                    fetch_wait = $urandom_range(1, 5);
                end
                if (return_valid && return_ack)
                begin
                    ret_done = 1'b1;
                    ack_due  = 2;
                end
            end
        end
    endtask

    initial
    begin
        int                            total;
        cache_bank_pkg::tag_t          tag;
        cache_bank_pkg::set_idx_t      set_sel;
        logic [`CB_OFFSET_W-1:0]       offset;
        cache_bank_pkg::port_t         port;

        void'($urandom(32'h61cd));
        clk_in        = 1'b0;
        reset_in      = 1'b1;
        access_packet = '0;
        miss_ack      = 1'b0;
        fetched_valid = 1'b0;
        fetched_data  = '0;
        return_ack    = 1'b0;
        errors        = 0;
        checks        = 0;
        hits          = 0;
        misses        = 0;
        cycle_count   = 0;
        for (int s = 0; s < `CB_NUM_SET; s++)
        begin
            m_valid[s] = '0;
            m_hist[s]  = '0;
        end

        repeat (2) @(posedge clk_in);
        #1;
        reset_in = 1'b0;

        // idle bank stays quiet
        repeat (3)
        begin
            next_cycle();
            check_value("access_ack", access_ack, 0);
            check_value("miss_valid", miss_valid, 0);
            check_value("fetched_ack", fetched_ack, 0);
            check_value("return_valid", return_valid, 0);
        end

        for (int i = 0; i < NUM_READS; i++)
        begin
            tag     = 12'h3a0 + 12'h051 * $urandom_range(0, TAGS_PER_SET - 1);
            set_sel = $urandom_range(0, `CB_NUM_SET - 1);
            offset  = $urandom();
            port    = $urandom();
            do_read(port, {tag, set_sel, offset});
        end
        access_packet = '0;

        repeat (4)
        begin
            next_cycle();
            check_value("access_ack", access_ack, 0);
            check_value("miss_valid", miss_valid, 0);
            check_value("return_valid", return_valid, 0);
        end

        total = errors + u_dut.u_checker.fail_count;
        $display("checks %0d, errors %0d, assertion failures %0d, hits %0d, misses %0d",
                 checks, errors, u_dut.u_checker.fail_count, hits, misses);
        if (total == 0)
        begin
            $display("TEST PASS");
        end
        else
        begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule
